// ==== build.f ====
source/snakePkg.sv
source/snakeCore.sv
source/fieldPainter.sv
source/bodyPainter.sv
source/pixelMixer.sv
source/snakeTop.sv
verif/snakeChecker.sv
verif/snakeTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the snake testbench with Verilator
verilator --binary --timing --timescale 1ns/1ps --top-module snakeTb -f build.f -o snakeSim &&
	./obj_dir/snakeSim > sim.log 2>&1 ||
	{ echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "all tests passed" sim.log && echo "Result PASS" || { echo "Result FAIL"; exit 1; }

// ==== verif/snake_testdata.txt ====
// kind dir level paused randX randY headX headY score over (kind 1 step, dir 0 up 1 down 2 left 3 right)
// kind pixX pixY video 0 0 0 0 rgb over (kind 2 pixel probe, all hex, kind 0 ends the list)
1 3 0 1 00 00 03 03 0000 0
1 3 0 0 00 00 04 03 0000 0
1 3 0 0 00 00 05 03 0000 0
2 08C 05A 1 0 0 0 0 2 0
2 0F0 041 1 0 0 0 0 4 0
2 001 0C8 1 0 0 0 0 7 0
2 12C 1DE 1 0 0 0 0 7 0
2 08C 05A 0 0 0 0 0 0 0
2 12C 12C 1 0 0 0 0 0 0
1 0 1 0 00 00 05 02 0000 0
1 0 1 0 00 00 05 01 0000 0
1 0 1 0 00 00 05 00 0000 0
1 0 1 0 00 00 05 12 0000 0
1 1 1 0 00 00 05 00 0000 0
1 1 1 0 00 00 05 01 0000 0
1 1 1 0 00 00 05 02 0000 0
1 3 0 0 00 00 06 02 0000 0
1 3 0 0 00 00 07 02 0000 0
1 3 0 0 00 00 08 02 0000 0
1 3 0 0 0A 02 09 02 0001 0
2 109 041 1 0 0 0 0 4 0
2 0D7 041 1 0 0 0 0 2 0
1 3 0 0 0B 02 0A 02 0002 0
1 3 0 0 0C 02 0B 02 0003 0
1 3 0 0 0D 02 0C 02 0004 0
2 0D7 041 1 0 0 0 0 2 0
2 0BE 041 1 0 0 0 0 0 0
1 3 0 0 0E 02 0D 02 0005 0
1 3 0 0 0F 02 0E 02 0006 0
1 3 0 0 10 02 0F 02 0007 0
1 3 0 0 11 02 10 02 0008 0
1 3 0 0 12 02 11 02 0009 0
1 3 0 0 13 02 12 02 0010 0
1 1 0 0 13 02 12 03 0010 0
1 2 0 0 13 02 11 03 0010 0
1 0 0 0 13 02 11 03 0010 1
2 12C 12C 1 0 0 0 0 1 1
1 0 0 1 00 00 03 03 0000 0
1 0 2 0 00 00 03 02 0000 0
1 0 2 0 00 00 03 01 0000 0
1 0 2 0 00 00 03 00 0000 0
1 0 2 0 00 00 03 00 0000 1
1 3 3 1 00 00 03 03 0000 0
1 3 3 0 00 00 04 03 0000 0
0 0 0 0 0 0 0 0 0 0

// ==== verif/snakeTb.sv ====
`timescale 1ns/1ps

module snakeTb;
	import snakePkg::*;

	localparam string dataFile = "verif/snake_testdata.txt";
	localparam int fields = 10; // Words per record
	localparam int depth = 64;

	logic clk;
	logic rst;
	logic frameTick;
	dirT dir;
	levelT level;
	logic paused;
	cellT randCell;
	pixelT pix;
	rgbT rgb;
	scoreT score;
	cellT head;
	logic gameOver;
	logic strobe;
	logic loaded;
	int checks;
	int errors;
	int fileErrors;
	int recCount;
	logic [15:0] words [fields*depth];

	snakeTop snakeTop_inst (.*);

	snakeChecker outputCheck (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Frame ticks per step at each level
	function automatic int framesFor(levelT lv);
		case (lv)
			levelEasy: return 8;
			levelNormal: return 6;
			levelHard: return 4;
			default: return 2;
		endcase
	endfunction

	// Called right after a rising edge
	task automatic pulseStrobe();
		#1 strobe = 1'b1;
		@(posedge clk);
		#1 strobe = 1'b0;
	endtask

	task automatic stepGame(int b);
		int n;
		n = framesFor(levelT'(words[b+2][1:0]));
		@(posedge clk);
		#1;
		dir = dirT'(words[b+1][1:0]);
		level = levelT'(words[b+2][1:0]);
		paused = words[b+3][0];
		randCell.x = words[b+4][4:0];
		randCell.y = words[b+5][4:0];
		repeat (n) begin
			@(posedge clk);
			#1 frameTick = 1'b1;
			@(posedge clk);
			#1 frameTick = 1'b0;
			@(posedge clk);
		end
		pulseStrobe();
	endtask

	task automatic probePixel(int b);
		@(posedge clk);
		#1;
		pix.x = words[b+1][9:0];
		pix.y = words[b+2][9:0];
		pix.videoOn = words[b+3][0];
		@(posedge clk); // Painter stage
		#1 pix = '0; // Pixel held for one cycle only
		@(posedge clk); // Mixer stage
		pulseStrobe();
	endtask

	initial begin
		int fd;
		int kind;
		rst = 1'b1;
		frameTick = 1'b0;
		dir = dirRight;
		level = levelEasy;
		paused = 1'b0;
		randCell = '0;
		pix = '0;
		strobe = 1'b0;
		loaded = 1'b0;
		fileErrors = 0;
		recCount = 0;
		for (int i = 0; i < fields*depth; i++)
			words[i] = '0;
		fd = $fopen(dataFile, "r");
		if (fd == 0) begin
			$display("Cannot open the test data file %s", dataFile);
			fileErrors++;
		end else begin
			$fclose(fd);
			$readmemh(dataFile, words);
		end
		while (recCount < depth && words[recCount*fields] != 16'd0)
			recCount++;
		if (fileErrors == 0 && recCount == 0) begin
			$display("The test data file holds no records");
			fileErrors++;
		end
		loaded = 1'b1;
		repeat (3) @(posedge clk);
		#1 rst = 1'b0;
		for (int r = 0; r < recCount && fileErrors == 0; r++) begin
			kind = int'(words[r*fields]);
			if (kind == 1)
				stepGame(r*fields);
			else if (kind == 2)
				probePixel(r*fields);
			else begin
				$display("Record %0d has the unknown kind %0d", r, kind);
				fileErrors++;
			end
		end
		repeat (2) @(posedge clk);
		$display("Records %0d, checks %0d, errors %0d, file errors %0d",
			recCount, checks, errors, fileErrors);
		if (errors == 0 && fileErrors == 0 && checks == recCount) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Budget of 8 frames of 10 cycles per record
	initial begin
		int limit;
		wait (loaded);
		limit = recCount * 8 * 10 * 4 + 1000;
		#(limit);
		$display("Timeout after %0d ns with records still running", limit);
		$display("tests failed");
		$finish;
	end

endmodule

// ==== verif/snakeChecker.sv ====
`timescale 1ns/1ps

module snakeChecker (
	input logic clk,
	input logic strobe,
	input snakePkg::cellT head,
	input snakePkg::scoreT score,
	input logic gameOver,
	input snakePkg::rgbT rgb,
	output int checks,
	output int errors
);
	import snakePkg::*;

	localparam string dataFile = "verif/snake_testdata.txt";
	localparam int fields = 10;
	localparam int depth = 64;

	logic [15:0] words [fields*depth];
	int rec = 0; // Advances once per strobe
	int checkCount = 0;
	int errorCount = 0;

	assign checks = checkCount;
	assign errors = errorCount;

	task automatic mismatch(string msg);
		$display("[ERROR] %0d ns: record %0d %s", $time, rec, msg);
		errorCount++;
	endtask

	initial begin
		int fd;
		for (int i = 0; i < fields*depth; i++)
			words[i] = '0;
		fd = $fopen(dataFile, "r");
		if (fd != 0) begin
			$fclose(fd);
			$readmemh(dataFile, words);
		end
	end

	always @(posedge clk) begin
		int b;
		cellT expHead;
		scoreT expScore;
		logic expOver;
		if (strobe) begin
			b = rec * fields;
			expOver = words[b+9][0];
			checkCount++;
			if (words[b] == 16'd1) begin
				expHead.x = words[b+6][4:0];
				expHead.y = words[b+7][4:0];
				expScore = words[b+8];
				if (head !== expHead)
					mismatch($sformatf("head (%0d,%0d), expected (%0d,%0d)",
						head.x, head.y, expHead.x, expHead.y));
				if (score !== expScore)
					mismatch($sformatf("score %h, expected %h", score, expScore));
			end else if (words[b] == 16'd2) begin
				if (rgb !== words[b+8][2:0])
					mismatch($sformatf("rgb %b, expected %b", rgb, words[b+8][2:0]));
			end else begin
				$display("Record %0d in the test data file is neither a step nor a probe", rec);
				errorCount++;
			end
			if (gameOver !== expOver)
				mismatch($sformatf("gameOver %b, expected %b", gameOver, expOver));
			rec++;
		end
	end

endmodule

// ==== source/snakeTop.sv ====
`timescale 1ns/1ps

module snakeTop (
	input logic clk,
	input logic rst,
	input logic frameTick,
	input snakePkg::dirT dir,
	input snakePkg::levelT level,
	input logic paused,
	input snakePkg::cellT randCell,
	input snakePkg::pixelT pix,
	output snakePkg::rgbT rgb,
	output snakePkg::scoreT score,
	output snakePkg::cellT head,
	output logic gameOver
);
	import snakePkg::*;

	cellT fruit;
	bodyT body;
	paintT paint;
	logic onBody;
	logic videoOnQ;

	snakeCore core (
		.clk(clk),
		.rst(rst),
		.frameTick(frameTick),
		.dir(dir),
		.level(level),
		.paused(paused),
		.randCell(randCell),
		.head(head),
		.fruit(fruit),
		.body(body),
		.score(score),
		.gameOver(gameOver)
	);

	// Render pipeline, two cycles from pix to rgb
	fieldPainter field (
		.clk(clk),
		.rst(rst),
		.pix(pix),
		.head(head),
		.fruit(fruit),
		.paint(paint),
		.videoOnOut(videoOnQ)
	);

	bodyPainter bodyPaint (
		.clk(clk),
		.rst(rst),
		.pix(pix),
		.body(body),
		.onBody(onBody)
	);

	pixelMixer mixer (
		.clk(clk),
		.rst(rst),
		.paint(paint),
		.onBody(onBody),
		.videoOn(videoOnQ),
		.gameOver(gameOver),
		.rgb(rgb)
	);

endmodule

// ==== source/pixelMixer.sv ====
`timescale 1ns/1ps

module pixelMixer (
	input logic clk,
	input logic rst,
	input snakePkg::paintT paint,
	input logic onBody,
	input logic videoOn,
	input logic gameOver,
	output snakePkg::rgbT rgb
);
	import snakePkg::*;

	logic gameOverQ; // Same stage as the painter outputs
	rgbT colour;

	always_comb begin
		if (!videoOn)
			colour = colBlack;
		else if (paint.wall)
			colour = colWall;
		else if (gameOverQ)
			colour = colDead;
		else if (paint.head || onBody)
			colour = colSnake;
		else if (paint.fruit)
			colour = colFruit;
		else
			colour = colBlack;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			gameOverQ <= 1'b0;
			rgb <= colBlack;
		end else begin
			gameOverQ <= gameOver;
			rgb <= colour;
		end
	end

endmodule

// ==== source/bodyPainter.sv ====
`timescale 1ns/1ps

module bodyPainter (
	input logic clk,
	input logic rst,
	input snakePkg::pixelT pix,
	input snakePkg::bodyT body,
	output logic onBody
);
	import snakePkg::*;

	logic [maxSegments-1:0] segHit;

	// One rectangle test per segment, inactive ones masked by count
	always_comb begin
		for (int i = 0; i < maxSegments; i++)
			segHit[i] = (5'(i) < body.count) && pixInCell(pix, body.seg[i]);
	end

	always_ff @(posedge clk) begin
		if (rst)
			onBody <= 1'b0;
		else
			onBody <= |segHit;
	end

endmodule

// ==== source/fieldPainter.sv ====
`timescale 1ns/1ps

module fieldPainter (
	input logic clk,
	input logic rst,
	input snakePkg::pixelT pix,
	input snakePkg::cellT head,
	input snakePkg::cellT fruit,
	output snakePkg::paintT paint,
	output logic videoOnOut
);
	import snakePkg::*;

	logic onWall;
	logic onHead;
	logic onFruit;

	// Left and top bands begin at pixel 0
	assign onWall = (pix.x <= 10'(wallLeftMax)) ||
		((pix.x >= 10'(wallRightMin)) && (pix.x <= 10'(wallRightMax))) ||
		(pix.y <= 10'(wallTopMax)) ||
		((pix.y >= 10'(wallBottomMin)) && (pix.y <= 10'(wallBottomMax)));

	assign onHead = pixInCell(pix, head);
	assign onFruit = pixInCell(pix, fruit);

	always_ff @(posedge clk) begin
		if (rst) begin
			paint <= '0;
			videoOnOut <= 1'b0;
		end else begin
			paint.wall <= onWall;
			paint.head <= onHead;
			paint.fruit <= onFruit;
			videoOnOut <= pix.videoOn; // Travels with the paint bits
		end
	end

endmodule

// ==== source/snakeCore.sv ====
`timescale 1ns/1ps

module snakeCore (
	input logic clk,
	input logic rst,
	input logic frameTick,
	input snakePkg::dirT dir,
	input snakePkg::levelT level,
	input logic paused,
	input snakePkg::cellT randCell,
	output snakePkg::cellT head,
	output snakePkg::cellT fruit,
	output snakePkg::bodyT body,
	output snakePkg::scoreT score,
	output logic gameOver
);
	import snakePkg::*;

	logic [3:0] frameCnt;
	logic stepTick;
	gameStateT state;
	cellT [maxSegments-1:0] segs;
	logic [4:0] segCount;

	cellT nextHead;
	logic deadlyWalls;
	logic hitWall;
	logic hitBody;
	logic eat;
	logic moveOk;

	// Decimal increment, 9999 rolls over to 0000
	function automatic scoreT bumpScore(scoreT s);
		scoreT r;
		logic carry;
		r = s;
		carry = 1'b1;
		for (int i = 0; i < 4; i++) begin
			if (carry) begin
				if (r.digit[i] == 4'd9) begin
					r.digit[i] = 4'd0;
				end else begin
					r.digit[i] = r.digit[i] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		return r;
	endfunction

	assign stepTick = frameTick && (frameCnt >= stepFrames[level] - 4'd1);
	assign deadlyWalls = (level == levelHard) || (level == levelExpert);

	// Next head position with wrap or wall hit
	always_comb begin
		nextHead = head;
		hitWall = 1'b0;
		case (dir)
			dirUp: begin
				if (head.y == 5'd0) begin
					hitWall = deadlyWalls;
					nextHead.y = 5'(gridRows - 1);
				end else begin
					nextHead.y = head.y - 5'd1;
				end
			end
			dirDown: begin
				if (head.y == 5'(gridRows - 1)) begin
					hitWall = deadlyWalls;
					nextHead.y = 5'd0;
				end else begin
					nextHead.y = head.y + 5'd1;
				end
			end
			dirLeft: begin
				if (head.x == 5'd0) begin
					hitWall = deadlyWalls;
					nextHead.x = 5'(gridCols - 1);
				end else begin
					nextHead.x = head.x - 5'd1;
				end
			end
			default: begin
				if (head.x == 5'(gridCols - 1)) begin
					hitWall = deadlyWalls;
					nextHead.x = 5'd0;
				end else begin
					nextHead.x = head.x + 5'd1;
				end
			end
		endcase
	end

	always_comb begin
		hitBody = 1'b0;
		for (int i = 0; i < maxSegments; i++) begin
			if ((5'(i) < segCount) && (segs[i] == nextHead))
				hitBody = 1'b1;
		end
	end

	assign eat = (nextHead == fruit);
	assign moveOk = stepTick && (state == statePlaying) && !paused && !hitWall && !hitBody;

	// Body follows the head, old head becomes segment 0
	always_ff @(posedge clk) begin
		if (moveOk)
			segs <= {segs[maxSegments-2:0], head};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			frameCnt <= 4'd0;
			head <= startHead;
			fruit <= startFruit;
			segCount <= 5'd0;
			score <= '0;
			state <= statePlaying;
		end else begin
			if (frameTick)
				frameCnt <= stepTick ? 4'd0 : frameCnt + 4'd1;
			if (stepTick) begin
				if (state == stateOver) begin
					if (paused) begin // Restart
						head <= startHead;
						fruit <= startFruit;
						segCount <= 5'd0;
						score <= '0;
						state <= statePlaying;
					end
				end else if (!paused) begin
					if (hitWall || hitBody) begin
						state <= stateOver;
					end else begin
						head <= nextHead;
						if (eat) begin
							if (segCount != 5'(maxSegments))
								segCount <= segCount + 5'd1;
							score <= bumpScore(score);
							fruit <= randCell;
						end
					end
				end
			end
		end
	end

	assign body.seg = segs;
	assign body.count = segCount;
	assign gameOver = (state == stateOver);

endmodule

// ==== source/snakePkg.sv ====
package snakePkg;

	// Grid geometry
	localparam int cellSize = 25;
	localparam int fieldOrigin = 2;
	localparam int gridCols = 24;
	localparam int gridRows = 19;

	// Wall bands in pixels, left and top start at 0
	localparam int wallLeftMax = 2;
	localparam int wallRightMin = 602;
	localparam int wallRightMax = 604;
	localparam int wallTopMax = 2;
	localparam int wallBottomMin = 477;
	localparam int wallBottomMax = 479;

	localparam int maxSegments = 24;

	typedef struct packed {
		logic [4:0] x;
		logic [4:0] y;
	} cellT;

	typedef struct packed {
		cellT [maxSegments-1:0] seg;
		logic [4:0] count; // Active segments
	} bodyT;

	// digit[0] holds the ones
	typedef struct packed {
		logic [3:0][3:0] digit;
	} scoreT;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic videoOn;
	} pixelT;

	typedef logic [2:0] rgbT;

	typedef struct packed {
		logic wall;
		logic head;
		logic fruit;
	} paintT;

	typedef enum logic [1:0] {dirUp, dirDown, dirLeft, dirRight} dirT;
	typedef enum logic [1:0] {levelEasy, levelNormal, levelHard, levelExpert} levelT;
	typedef enum logic {statePlaying, stateOver} gameStateT;

	localparam cellT startHead = '{x: 5'd3, y: 5'd3};
	localparam cellT startFruit = '{x: 5'd9, y: 5'd2};

	// Frame ticks per step, indexed by levelT
	localparam logic [3:0][3:0] stepFrames = {4'd2, 4'd4, 4'd6, 4'd8};

	localparam rgbT colWall = 3'b111;
	localparam rgbT colSnake = 3'b010;
	localparam rgbT colFruit = 3'b100;
	localparam rgbT colDead = 3'b001;
	localparam rgbT colBlack = 3'b000;

	// Cell rectangle is inclusive on both ends
	function automatic logic pixInCell(pixelT p, cellT c);
		logic [10:0] x0;
		logic [10:0] y0;
		x0 = 11'(fieldOrigin) + 11'(cellSize) * 11'(c.x);
		y0 = 11'(fieldOrigin) + 11'(cellSize) * 11'(c.y);
		return ({1'b0, p.x} >= x0) && ({1'b0, p.x} <= x0 + 11'(cellSize)) &&
			({1'b0, p.y} >= y0) && ({1'b0, p.y} <= y0 + 11'(cellSize));
	endfunction

endpackage
